// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module tb_decode_top -Mdir obj_dir -f build.f

run: compile
	-./obj_dir/Vtb_decode_top > sim.log 2>&1
	@cat sim.log
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit (
    input  logic [dec_pkg::XLEN-1:0] pc,
    input  logic [dec_pkg::XLEN-1:0] instr,
    input  logic [dec_pkg::XLEN-1:0] rs_val,
    input  logic [dec_pkg::XLEN-1:0] rt_val,
    input  dec_pkg::npc_op_t         npc_op,
    input  logic [dec_pkg::XLEN-1:0] imm_ext,
    output logic                     branch_taken,
    output logic [dec_pkg::XLEN-1:0] next_pc,
    output logic [dec_pkg::XLEN-1:0] link_val
);

    logic [dec_pkg::XLEN-1:0] pc_plus4;
    logic [dec_pkg::XLEN-1:0] br_target;
    logic [dec_pkg::XLEN-1:0] j_target;
    logic                     ops_equal;

    assign pc_plus4  = pc + 32'd4;
    assign link_val  = pc + 32'd8;
    assign br_target = pc_plus4 + {imm_ext[dec_pkg::XLEN-3:0], 2'b00};
    assign j_target  = {pc[31:28], instr[25:0], 2'b00}; // pseudo-direct
    assign ops_equal = (rs_val == rt_val);

    always_comb begin
        case (npc_op)
            dec_pkg::NPC_BRANCH_EQ: branch_taken = ops_equal;
            dec_pkg::NPC_BRANCH_NE: branch_taken = !ops_equal;
            dec_pkg::NPC_JUMP,
            dec_pkg::NPC_JUMP_REG:  branch_taken = 1'b1;
            default:                branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!branch_taken) begin
            next_pc = pc_plus4;
        end else begin
            case (npc_op)
                dec_pkg::NPC_JUMP:     next_pc = j_target;
                dec_pkg::NPC_JUMP_REG: next_pc = rs_val;
                default:               next_pc = br_target;
            endcase
        end
    end

endmodule

// ==== build.f ====
dec_pkg.sv
hs_if.sv
instr_intake.sv
instr_decoder.sv
reg_file.sv
branch_unit.sv
decode_stage.sv
issue_port.sv
decode_top.sv
tb_decode_top.sv

// ==== dec_pkg.sv ====
package dec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [3:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_t;
    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} ext_op_t;
    typedef enum logic [2:0] {
        NPC_SEQ, NPC_BRANCH_EQ, NPC_BRANCH_NE, NPC_JUMP, NPC_JUMP_REG
    } npc_op_t;
    typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA, DEST_NONE} dest_sel_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_t               alu_op;
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
        logic [XLEN-1:0]       imm_ext;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reg_we;
        logic                  mem_we;
        logic                  mem_rd;
        logic                  use_imm;
        logic                  branch_taken;
        logic [XLEN-1:0]       next_pc;
        logic [XLEN-1:0]       link_val;
    } dec_rec_t;

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    hs_if.receiver                         pkt_in,
    hs_if.sender                           rec_out,
    input  logic                           wb_we,
    input  logic [dec_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [dec_pkg::XLEN-1:0]       wb_data
);

    logic [dec_pkg::XLEN-1:0]       instr, pc, rs_val, rt_val, imm_ext, next_pc, link_val;
    logic [dec_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr, dest;
    dec_pkg::alu_op_t               alu_op;
    dec_pkg::dest_sel_t             dest_sel;
    dec_pkg::npc_op_t               npc_op;
    logic                           reg_we, mem_we, mem_rd, use_imm, branch_taken;
    logic                           capture, rec_valid, r0_ok;
    dec_pkg::dec_rec_t              rec_q;

    assign instr   = pkt_in.data.instr;
    assign pc      = pkt_in.data.pc;
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign capture = pkt_in.req && !pkt_in.ack && !rec_valid;
    assign rec_out.data = rec_q;

    instr_decoder i_decoder (
        .instr(instr), .alu_op(alu_op), .ext_op(), .dest_sel(dest_sel), .npc_op(npc_op),
        .reg_we(reg_we), .mem_we(mem_we), .mem_rd(mem_rd), .use_imm(use_imm), .imm_ext(imm_ext)
    );

    reg_file i_reg_file (
        .clk(clk), .arst_n(arst_n), .rd_addr1(rs_addr), .rd_addr2(rt_addr),
        .rd_data1(rs_val), .rd_data2(rt_val), .wr_en(wb_we), .wr_addr(wb_addr), .wr_data(wb_data)
    );

    branch_unit i_branch_unit (
        .pc(pc), .instr(instr), .rs_val(rs_val), .rt_val(rt_val), .npc_op(npc_op),
        .imm_ext(imm_ext), .branch_taken(branch_taken), .next_pc(next_pc), .link_val(link_val)
    );

    always_comb begin
        case (dest_sel)
            dec_pkg::DEST_RT: dest = rt_addr;
            dec_pkg::DEST_RD: dest = instr[15:11];
            dec_pkg::DEST_RA: dest = 5'd31; // jal link
            default:          dest = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_in.ack  <= 1'b0;
            rec_valid   <= 1'b0;
            rec_out.req <= 1'b0;
        end else begin
            if (capture) begin
                pkt_in.ack <= 1'b1;
                rec_valid  <= 1'b1;
            end else if (pkt_in.ack && !pkt_in.req) begin
                pkt_in.ack <= 1'b0;
            end
            if (rec_out.req && rec_out.ack) begin
                rec_out.req <= 1'b0;
                rec_valid   <= 1'b0;
            end else if (rec_valid && !rec_out.req && !rec_out.ack) begin
                rec_out.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rec_q <= '{pc: pc, alu_op: alu_op, rs_val: rs_val, rt_val: rt_val,
                       imm_ext: imm_ext, dest: dest, reg_we: reg_we, mem_we: mem_we,
                       mem_rd: mem_rd, use_imm: use_imm, branch_taken: branch_taken,
                       next_pc: next_pc, link_val: link_val};
        end
    end

    assign r0_ok = !pkt_in.req || rs_addr != '0 || rs_val == '0;

    // a write aimed at r0 must not leak into reads now or after the edge
    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_we && wb_addr == '0) |-> r0_ok ##1 r0_ok);

endmodule

// ==== decode_top.sv ====
`timescale 1ns/10ps

module decode_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_req,
    input  logic [dec_pkg::XLEN-1:0]       in_pc,
    input  logic [dec_pkg::XLEN-1:0]       in_instr,
    output logic                           in_ack,
    input  logic                           wb_we,
    input  logic [dec_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [dec_pkg::XLEN-1:0]       wb_data,
    output logic                           out_req,
    input  logic                           out_ack,
    output logic [dec_pkg::XLEN-1:0]       out_pc,
    output dec_pkg::alu_op_t               out_alu_op,
    output logic [dec_pkg::XLEN-1:0]       out_rs_val,
    output logic [dec_pkg::XLEN-1:0]       out_rt_val,
    output logic [dec_pkg::XLEN-1:0]       out_imm_ext,
    output logic [dec_pkg::REG_ADDR_W-1:0] out_dest,
    output logic                           out_reg_we,
    output logic                           out_mem_we,
    output logic                           out_mem_rd,
    output logic                           out_use_imm,
    output logic                           out_branch_taken,
    output logic [dec_pkg::XLEN-1:0]       out_next_pc,
    output logic [dec_pkg::XLEN-1:0]       out_link_val
);

    dec_pkg::dec_rec_t out_rec;

    hs_if #(.payload_t(dec_pkg::fetch_pkt_t)) fetch_link ();
    hs_if #(.payload_t(dec_pkg::dec_rec_t))   rec_link ();

    instr_intake i_intake (
        .clk(clk), .arst_n(arst_n), .in_req(in_req), .in_pc(in_pc), .in_instr(in_instr),
        .in_ack(in_ack), .pkt(fetch_link.sender)
    );

    decode_stage i_stage (
        .clk(clk), .arst_n(arst_n), .pkt_in(fetch_link.receiver), .rec_out(rec_link.sender),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    issue_port i_issue (
        .clk(clk), .arst_n(arst_n), .rec_in(rec_link.receiver), .out_req(out_req),
        .out_ack(out_ack), .out_rec(out_rec)
    );

    assign out_pc           = out_rec.pc;
    assign out_alu_op       = out_rec.alu_op;
    assign out_rs_val       = out_rec.rs_val;
    assign out_rt_val       = out_rec.rt_val;
    assign out_imm_ext      = out_rec.imm_ext;
    assign out_dest         = out_rec.dest;
    assign out_reg_we       = out_rec.reg_we;
    assign out_mem_we       = out_rec.mem_we;
    assign out_mem_rd       = out_rec.mem_rd;
    assign out_use_imm      = out_rec.use_imm;
    assign out_branch_taken = out_rec.branch_taken;
    assign out_next_pc      = out_rec.next_pc;
    assign out_link_val     = out_rec.link_val;

endmodule

// ==== hs_if.sv ====
`timescale 1ns/10ps

interface hs_if #(
    parameter type payload_t = logic
);

    logic     req;  // sender side
    logic     ack;  // receiver side
    payload_t data; // held while req is high

    modport sender (
        output req,
        output data,
        input  ack
    );

    modport receiver (
        input  req,
        input  data,
        output ack
    );

endinterface

// ==== instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  logic [dec_pkg::XLEN-1:0] instr,
    output dec_pkg::alu_op_t         alu_op,
    output dec_pkg::ext_op_t         ext_op,
    output dec_pkg::dest_sel_t       dest_sel,
    output dec_pkg::npc_op_t         npc_op,
    output logic                     reg_we,
    output logic                     mem_we,
    output logic                     mem_rd,
    output logic                     use_imm,
    output logic [dec_pkg::XLEN-1:0] imm_ext
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];
    assign reg_we = (dest_sel != dec_pkg::DEST_NONE);

    always_comb begin
        alu_op   = dec_pkg::ALU_ADD;
        ext_op   = dec_pkg::EXT_SIGN;
        dest_sel = dec_pkg::DEST_NONE; // nop unless matched below
        npc_op   = dec_pkg::NPC_SEQ;
        mem_we   = 1'b0;
        mem_rd   = 1'b0;
        use_imm  = 1'b0;
        case (opcode)
            dec_pkg::OP_RTYPE: begin
                dest_sel = dec_pkg::DEST_RD;
                case (funct)
                    dec_pkg::FN_ADDU: alu_op = dec_pkg::ALU_ADD;
                    dec_pkg::FN_SUBU: alu_op = dec_pkg::ALU_SUB;
                    dec_pkg::FN_AND:  alu_op = dec_pkg::ALU_AND;
                    dec_pkg::FN_OR:   alu_op = dec_pkg::ALU_OR;
                    dec_pkg::FN_SLT:  alu_op = dec_pkg::ALU_SLT;
                    dec_pkg::FN_JR: begin
                        dest_sel = dec_pkg::DEST_NONE;
                        npc_op   = dec_pkg::NPC_JUMP_REG;
                    end
                    default: dest_sel = dec_pkg::DEST_NONE;
                endcase
            end
            dec_pkg::OP_ADDIU: begin
                dest_sel = dec_pkg::DEST_RT;
                use_imm  = 1'b1;
            end
            dec_pkg::OP_ORI: begin
                alu_op   = dec_pkg::ALU_OR;
                ext_op   = dec_pkg::EXT_ZERO;
                dest_sel = dec_pkg::DEST_RT;
                use_imm  = 1'b1;
            end
            dec_pkg::OP_LUI: begin
                alu_op   = dec_pkg::ALU_LUI;
                ext_op   = dec_pkg::EXT_UPPER;
                dest_sel = dec_pkg::DEST_RT;
                use_imm  = 1'b1;
            end
            dec_pkg::OP_LW: begin
                dest_sel = dec_pkg::DEST_RT;
                use_imm  = 1'b1;
                mem_rd   = 1'b1;
            end
            dec_pkg::OP_SW: begin
                use_imm = 1'b1; // address = rs + imm
                mem_we  = 1'b1;
            end
            dec_pkg::OP_BEQ: npc_op = dec_pkg::NPC_BRANCH_EQ;
            dec_pkg::OP_BNE: npc_op = dec_pkg::NPC_BRANCH_NE;
            dec_pkg::OP_J:   npc_op = dec_pkg::NPC_JUMP;
            dec_pkg::OP_JAL: begin
                npc_op   = dec_pkg::NPC_JUMP;
                dest_sel = dec_pkg::DEST_RA;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (ext_op)
            dec_pkg::EXT_ZERO:  imm_ext = {16'h0000, imm};
            dec_pkg::EXT_UPPER: imm_ext = {imm, 16'h0000};
            default:            imm_ext = {{16{imm[15]}}, imm};
        endcase
    end

endmodule

// ==== instr_intake.sv ====
`timescale 1ns/10ps

module instr_intake (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_req,
    input  logic [dec_pkg::XLEN-1:0] in_pc,
    input  logic [dec_pkg::XLEN-1:0] in_instr,
    output logic                     in_ack,
    hs_if.sender                     pkt
);

    dec_pkg::fetch_pkt_t pkt_buf;
    logic                buf_valid;
    logic                capture;

    assign capture  = in_req && !in_ack && !buf_valid;
    assign pkt.data = pkt_buf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_ack    <= 1'b0;
            buf_valid <= 1'b0;
            pkt.req   <= 1'b0;
        end else begin
            if (capture) begin
                in_ack    <= 1'b1;
                buf_valid <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            if (pkt.req && pkt.ack) begin
                pkt.req   <= 1'b0; // stage has it
                buf_valid <= 1'b0;
            end else if (buf_valid && !pkt.req && !pkt.ack) begin
                pkt.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) pkt_buf <= '{pc: in_pc, instr: in_instr};
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        capture |-> in_pc[1:0] == 2'b00);

    // inward data frozen for the whole req phase
    a_pkt_stable: assert property (@(posedge clk) disable iff (!arst_n)
        pkt.req && $past(pkt.req) |-> $stable(pkt.data));

endmodule

// ==== issue_port.sv ====
`timescale 1ns/10ps

module issue_port (
    input  logic              clk,
    input  logic              arst_n,
    hs_if.receiver            rec_in,
    output logic              out_req,
    input  logic              out_ack,
    output dec_pkg::dec_rec_t out_rec
);

    logic rec_valid;
    logic wait_low; // req dropped while ack is high
    logic capture;

    assign capture = rec_in.req && !rec_in.ack && !rec_valid && !wait_low;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rec_in.ack <= 1'b0;
            rec_valid  <= 1'b0;
            wait_low   <= 1'b0;
            out_req    <= 1'b0;
        end else begin
            if (capture) begin
                rec_in.ack <= 1'b1;
                rec_valid  <= 1'b1;
            end else if (rec_in.ack && !rec_in.req) begin
                rec_in.ack <= 1'b0;
            end
            if (out_req && out_ack) begin
                out_req   <= 1'b0;
                rec_valid <= 1'b0;
                wait_low  <= 1'b1;
            end else if (rec_valid && !out_req) begin
                out_req <= 1'b1;
            end
            if (wait_low && !out_ack) wait_low <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) out_rec <= rec_in.data;
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(out_req) |-> $past(out_ack));

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [dec_pkg::REG_ADDR_W-1:0] rd_addr1,
    input  logic [dec_pkg::REG_ADDR_W-1:0] rd_addr2,
    output logic [dec_pkg::XLEN-1:0]       rd_data1,
    output logic [dec_pkg::XLEN-1:0]       rd_data2,
    input  logic                           wr_en,
    input  logic [dec_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [dec_pkg::XLEN-1:0]       wr_data
);

    localparam int NUM_REGS = 2 ** dec_pkg::REG_ADDR_W;

    logic [dec_pkg::XLEN-1:0] regs [NUM_REGS];

    function automatic logic [dec_pkg::XLEN-1:0] read_port(
        input logic [dec_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wr_en && wr_addr == addr) begin
            return wr_data; // bypass same-cycle writeback
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data1 = read_port(rd_addr1);
        rd_data2 = read_port(rd_addr2);
    end

endmodule

// ==== tb_decode_top.sv ====
`timescale 1ns/10ps

module tb_decode_top;

    localparam int TIMEOUT = 200; // cycles allowed per wait

    logic             clk;
    logic             arst_n;
    logic             in_req;
    logic [31:0]      in_pc;
    logic [31:0]      in_instr;
    logic             in_ack;
    logic             wb_we;
    logic [4:0]       wb_addr;
    logic [31:0]      wb_data;
    logic             out_req;
    logic             out_ack;
    logic [31:0]      out_pc;
    dec_pkg::alu_op_t out_alu_op;
    logic [31:0]      out_rs_val;
    logic [31:0]      out_rt_val;
    logic [31:0]      out_imm_ext;
    logic [4:0]       out_dest;
    logic             out_reg_we;
    logic             out_mem_we;
    logic             out_mem_rd;
    logic             out_use_imm;
    logic             out_branch_taken;
    logic [31:0]      out_next_pc;
    logic [31:0]      out_link_val;

    logic [31:0]       rf_model [32];
    dec_pkg::dec_rec_t exp_q [$];
    logic [31:0]       cur_pc;
    logic [31:0]       lfsr_state = 32'd33;
    int                err_count = 0;
    int                check_count = 0;
    int                test_count = 0;

    decode_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    // reference model of the decode rules
    function automatic dec_pkg::dec_rec_t predict_rec(input logic [31:0] pc,
                                                      input logic [31:0] instr);
        dec_pkg::dec_rec_t r;
        logic [5:0]        op;
        logic [15:0]       imm;
        logic              eq;
        op  = instr[31:26];
        imm = instr[15:0];
        r = '0;
        r.pc       = pc;
        r.alu_op   = dec_pkg::ALU_ADD;
        r.rs_val   = rf_model[instr[25:21]];
        r.rt_val   = rf_model[instr[20:16]];
        r.imm_ext  = {{16{imm[15]}}, imm};
        r.next_pc  = pc + 32'd4;
        r.link_val = pc + 32'd8;
        eq = (r.rs_val == r.rt_val);
        case (op)
            6'h00: begin // OP_RTYPE
                r.dest   = instr[15:11];
                r.reg_we = 1'b1;
                case (instr[5:0])
                    6'h21: r.alu_op = dec_pkg::ALU_ADD; // FN_ADDU
                    6'h23: r.alu_op = dec_pkg::ALU_SUB; // FN_SUBU
                    6'h24: r.alu_op = dec_pkg::ALU_AND; // FN_AND
                    6'h25: r.alu_op = dec_pkg::ALU_OR;  // FN_OR
                    6'h2a: r.alu_op = dec_pkg::ALU_SLT; // FN_SLT
                    6'h08: begin // FN_JR
                        r.dest         = '0;
                        r.reg_we       = 1'b0;
                        r.branch_taken = 1'b1;
                        r.next_pc      = r.rs_val;
                    end
                    default: begin
                        r.dest   = '0;
                        r.reg_we = 1'b0;
                    end
                endcase
            end
            6'h09, 6'h23: begin // OP_ADDIU, OP_LW
                r.dest    = instr[20:16];
                r.reg_we  = 1'b1;
                r.use_imm = 1'b1;
                r.mem_rd  = (op == 6'h23);
            end
            6'h0d, 6'h0f: begin // OP_ORI, OP_LUI
                r.alu_op  = (op == 6'h0d) ? dec_pkg::ALU_OR : dec_pkg::ALU_LUI;
                r.imm_ext = (op == 6'h0d) ? {16'h0000, imm} : {imm, 16'h0000};
                r.dest    = instr[20:16];
                r.reg_we  = 1'b1;
                r.use_imm = 1'b1;
            end
            6'h2b: begin // OP_SW
                r.use_imm = 1'b1;
                r.mem_we  = 1'b1;
            end
            6'h04, 6'h05: begin // OP_BEQ, OP_BNE
                r.branch_taken = (op == 6'h04) ? eq : !eq;
                if (r.branch_taken) r.next_pc = pc + 32'd4 + {r.imm_ext[29:0], 2'b00};
            end
            6'h02, 6'h03: begin // OP_J, OP_JAL
                r.branch_taken = 1'b1;
                r.next_pc      = {pc[31:28], instr[25:0], 2'b00};
                if (op == 6'h03) begin
                    r.dest   = 5'd31;
                    r.reg_we = 1'b1;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED time %0t: %s expected %h got %h", $time, name, exp, got);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (in_ack !== level) report_error($sformatf("in_ack never went to %0b", level));
    endtask

    task automatic wait_out_req(input logic level);
        int n;
        n = 0;
        while (out_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (out_req !== level) report_error($sformatf("out_req never went to %0b", level));
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb_we   = 1'b1;
        wb_addr = addr;
        wb_data = data;
        @(negedge clk);
        wb_we = 1'b0;
        if (addr != 5'd0) rf_model[addr] = data;
    endtask

    task automatic send_instr(input logic [31:0] instr);
        exp_q.push_back(predict_rec(cur_pc, instr));
        @(negedge clk);
        in_pc    = cur_pc;
        in_instr = instr;
        in_req   = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic expect_rec();
        dec_pkg::dec_rec_t e;
        wait_out_req(1'b1);
        if (exp_q.size() == 0) begin
            report_error("record came out with no instruction outstanding");
        end else begin
            e = exp_q.pop_front();
            check_val("out_pc", out_pc, e.pc);
            check_val("out_alu_op", 32'(out_alu_op), 32'(e.alu_op));
            check_val("out_rs_val", out_rs_val, e.rs_val);
            check_val("out_rt_val", out_rt_val, e.rt_val);
            check_val("out_imm_ext", out_imm_ext, e.imm_ext);
            check_val("out_dest", 32'(out_dest), 32'(e.dest));
            check_val("out_reg_we", 32'(out_reg_we), 32'(e.reg_we));
            check_val("out_mem_we", 32'(out_mem_we), 32'(e.mem_we));
            check_val("out_mem_rd", 32'(out_mem_rd), 32'(e.mem_rd));
            check_val("out_use_imm", 32'(out_use_imm), 32'(e.use_imm));
            check_val("out_branch_taken", 32'(out_branch_taken), 32'(e.branch_taken));
            check_val("out_next_pc", out_next_pc, e.next_pc);
            check_val("out_link_val", out_link_val, e.link_val);
        end
        out_ack = 1'b1;
        wait_out_req(1'b0);
        out_ack = 1'b0;
    endtask

    task automatic decode_one(input logic [31:0] instr);
        send_instr(instr);
        expect_rec();
    endtask

    task automatic finish_test(input string name, input int start);
        test_count++;
        $display("test %s: %s, %0d errors", name, (err_count == start) ? "ok" : "FAILED",
                 err_count - start);
    endtask

    task automatic decode_rtype_ops();
        int start;
        start = err_count;
        for (int r = 1; r < 9; r++) write_reg(5'(r), rand_bits(32));
        write_reg(5'd0, rand_bits(32)); // r0 must still read zero
        decode_one(r_type(5'd1, 5'd2, 5'd10, 6'h21)); // FN_ADDU
        decode_one(r_type(5'd3, 5'd4, 5'd11, 6'h23)); // FN_SUBU
        decode_one(r_type(5'd5, 5'd6, 5'd12, 6'h24)); // FN_AND
        decode_one(r_type(5'd7, 5'd8, 5'd13, 6'h25)); // FN_OR
        decode_one(r_type(5'd8, 5'd1, 5'd14, 6'h2a)); // FN_SLT
        decode_one(r_type(5'd0, 5'd0, 5'd15, 6'h21));
        finish_test("r-type", start);
    endtask

    task automatic decode_immediates();
        int start;
        start = err_count;
        decode_one(i_type(6'h09, 5'd1, 5'd16, 16'h8004)); // OP_ADDIU negative imm
        decode_one(i_type(6'h09, 5'd2, 5'd17, 16'h0123));
        decode_one(i_type(6'h0d, 5'd3, 5'd18, 16'hf00f)); // OP_ORI
        decode_one(i_type(6'h0f, 5'd0, 5'd19, 16'hbeef)); // OP_LUI
        decode_one(i_type(6'h23, 5'd4, 5'd20, 16'hfffc)); // OP_LW
        decode_one(i_type(6'h2b, 5'd5, 5'd6, 16'h0010));  // OP_SW
        finish_test("immediates", start);
    endtask

    task automatic resolve_branches();
        int          start;
        logic [31:0] v;
        start = err_count;
        v = rand_bits(32);
        write_reg(5'd21, v);
        write_reg(5'd22, v);
        write_reg(5'd23, ~v);
        decode_one(i_type(6'h04, 5'd21, 5'd22, 16'h0010)); // OP_BEQ taken forward
        decode_one(i_type(6'h04, 5'd21, 5'd22, 16'hfff8)); // taken backward
        decode_one(i_type(6'h04, 5'd21, 5'd23, 16'h0040));
        decode_one(i_type(6'h05, 5'd21, 5'd23, 16'hfff0)); // OP_BNE
        decode_one(i_type(6'h05, 5'd21, 5'd22, 16'h0020));
        finish_test("branches", start);
    endtask

    task automatic resolve_jumps();
        int          start;
        logic [31:0] t;
        start = err_count;
        cur_pc = 32'h9000_1000; // upper pc bits feed the jump target
        t = rand_bits(26);
        decode_one(j_type(6'h02, t[25:0])); // OP_J
        t = rand_bits(26);
        decode_one(j_type(6'h03, t[25:0])); // OP_JAL
        decode_one(r_type(5'd7, 5'd0, 5'd0, 6'h08)); // FN_JR
        decode_one(i_type(6'h3f, 5'd1, 5'd2, 16'h1234)); // unknown opcode
        decode_one(r_type(5'd1, 5'd2, 5'd3, 6'h3f)); // unknown funct
        finish_test("jumps", start);
    endtask

    task automatic hold_under_backpressure();
        int          start;
        logic        acked;
        logic [31:0] instr4;
        start  = err_count;
        acked  = 1'b0;
        instr4 = i_type(6'h23, 5'd6, 5'd27, 16'h0008);
        out_ack = 1'b0;
        send_instr(i_type(6'h09, 5'd1, 5'd24, 16'h0001));
        send_instr(r_type(5'd2, 5'd3, 5'd25, 6'h23));
        send_instr(i_type(6'h0d, 5'd4, 5'd26, 16'h00ff));
        exp_q.push_back(predict_rec(cur_pc, instr4));
        @(negedge clk);
        in_pc    = cur_pc;
        in_instr = instr4;
        in_req   = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (in_ack) acked = 1'b1;
        end
        check_val("in_ack", 32'(acked), 32'd0); // fourth waits while the pipeline is full
        fork
            begin
                wait_in_ack(1'b1);
                in_req = 1'b0;
                wait_in_ack(1'b0);
                cur_pc = cur_pc + 32'd4;
                send_instr(r_type(5'd5, 5'd6, 5'd28, 6'h2a));
            end
            repeat (5) expect_rec();
        join
        finish_test("back-pressure", start);
    endtask

    task automatic bypass_writeback();
        int          start;
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] instr;
        start   = err_count;
        old_val = rand_bits(32);
        new_val = ~old_val;
        instr   = r_type(5'd9, 5'd0, 5'd29, 6'h21);
        write_reg(5'd9, old_val);
        rf_model[9] = new_val; // capture must see the bypassed value
        exp_q.push_back(predict_rec(cur_pc, instr));
        rf_model[9] = old_val;
        @(negedge clk);
        in_pc    = cur_pc;
        in_instr = instr;
        in_req   = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        @(negedge clk); // stage captures at the next rising edge
        wb_we   = 1'b1;
        wb_addr = 5'd9;
        wb_data = new_val;
        @(negedge clk);
        wb_data = old_val; // restore so a late capture reads the old value
        @(negedge clk);
        wb_we = 1'b0;
        wait_in_ack(1'b0);
        cur_pc = cur_pc + 32'd4;
        expect_rec();
        finish_test("write-through", start);
    endtask

    initial begin
        arst_n   = 1'b0;
        in_req   = 1'b0;
        in_pc    = '0;
        in_instr = '0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        out_ack  = 1'b0;
        cur_pc   = 32'h0040_0000;
        for (int i = 0; i < 32; i++) rf_model[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_val("in_ack", 32'(in_ack), 32'd0);
        check_val("out_req", 32'(out_req), 32'd0);
        decode_rtype_ops();
        decode_immediates();
        resolve_branches();
        resolve_jumps();
        hold_under_backpressure();
        bypass_writeback();
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
